/* all.f */
ti_bus_pkg.sv
ti_loader_pkg.sv
bus_decoder.sv
xaddr_mapper.sv
ready_ctrl.sv
loader_regs.sv
ti_glue_top.sv
tb_ti_glue.sv

/* Bender.yml */
package:
  name: ti_glue

sources:
  - ti_bus_pkg.sv
  - ti_loader_pkg.sv
  - bus_decoder.sv
  - xaddr_mapper.sv
  - ready_ctrl.sv
  - loader_regs.sv
  - ti_glue_top.sv
  - target: test
    files:
      - tb_ti_glue.sv

/* tb_ti_glue.sv */
// Directed testbench for the console bus glue
// Runs memory map, strobe, banking, ready, read mux and loader tests
// against ti_glue_top, one line per test, counts at the end
module tb_ti_glue import ti_bus_pkg::*, ti_loader_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // Rough cycles per test for reset, map, strobes, bank, ready, mux and loader
  localparam int TEST_CYCLES = 16 + 65 + 30 + 20 + 25 + 10 + 130;
  localparam int WATCHDOG_NS = (TEST_CYCLES + 400) * 40;

  logic clk, cpu_reset, rd_i, wr_i, cpu_ready_o;
  logic grom_selected_i, grom_reg_out_i;
  logic mem_rd_ack_i, mem_wr_ack_i, vdp_rd_ack_i, vdp_wr_ack_i;
  logic cart_cs_o, xram_ce_o, vdp_ce_o, vdp_rd_o, vdp_wr_o, grom_rd_o, grom_wr_o;
  logic sound_wr_o, mem_rd_rq_o, mem_wr_rq_o, mem_active_n_o;
  logic loader_rd_rq_i, loader_wr_rq_i, loader_rd_ack_o, loader_wr_ack_o;
  logic reset_switch_n_i, cpu_hold_o, cpu_reset_req_o;
  logic [KEY_ROW_W-1:0] key_row_sel_i;
  cpu_word_t    ab_i, db_in_o, vdp_data_i, xram_data_i;
  cpu_word_t    cpu_ir_i, cpu_ir_pc_i, cpu_ir_pc2_i;
  grom_addr_t   grom_addr_i;
  byte_t        grom_data_i, loader_wdata_i, loader_rdata_o, ps2_keyline_i, key_cols_o;
  mem_region_e  region_o;
  cart_page_t   cart_page_o;
  xaddr_t       xaddr_o;
  loader_addr_t loader_addr_i;

  int errors = 0;
  int checks = 0;
  logic [31:0] lcg_state = 32'd16;  // Seed

  ti_glue_top UUT (.*);

  always #20 clk = !clk;  // 40 ns period

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // ------------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------------
  task automatic check_word(input cpu_word_t got, input cpu_word_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_xaddr(input xaddr_t got, input xaddr_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t: %s, got %b expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic check_region(input mem_region_e got, input mem_region_e exp,
                              input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t: %s, got %s expected %s", $time, msg, got.name(), exp.name());
    end
  endtask

  task automatic finish_test(input string name, input int e0);
    $display("%-12s finished, %0d errors", name, errors - e0);
  endtask

  // Memory map from the console address table
  function automatic logic exp_xram_ce(cpu_word_t a, logic is_rd);
    if (a <= 16'h1FFF) return is_rd;                      // Console ROM
    if (a <= 16'h3FFF) return 1'b1;                       // Low RAM
    if (a >= 16'h6000 && a <= 16'h7FFF) return is_rd;     // Cartridge ROM
    if (a >= 16'h8000 && a <= 16'h83FF) return 1'b1;      // Scratchpad
    if (a[15:8] == 8'h98) return !a[1];                   // GROM data port
    return a >= 16'hA000;
  endfunction

  // Region of an address from the same table
  function automatic mem_region_e exp_region(cpu_word_t a);
    if (a <= 16'h1FFF) return REG_ROM;
    if (a <= 16'h3FFF) return REG_LOW_RAM;
    if (a >= 16'h6000 && a <= 16'h7FFF) return REG_CART;
    if (a >= 16'h8000 && a <= 16'h83FF) return REG_SCRATCH;
    if (a >= 16'hA000) return REG_HIGH_RAM;
    case (a[15:8])
      8'h84:   return REG_SOUND;
      8'h88:   return REG_VDP_RD;
      8'h8C:   return REG_VDP_WR;
      8'h98:   return REG_GROM_RD;
      8'h9C:   return REG_GROM_WR;
      default: return REG_OTHER;
    endcase
  endfunction

  // ------------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------------
  task automatic test_memory_map();
    logic [31:0] r;
    cpu_word_t   a;
    logic        is_rd;
    byte_t       pages [8] = '{8'h88, 8'h8C, 8'h98, 8'h9C, 8'h84, 8'h00, 8'h60, 8'h83};
    int          e0;
    e0 = errors;
    for (int i = 0; i < 64; i++) begin
      r = lcg_next();
      a = r[31:16];
      if (r[11:10] == 2'b00) a[15:8] = pages[r[14:12]];  // Bias toward device pages
      is_rd = r[15];
      @(posedge clk);
      ab_i <= a;
      rd_i <= is_rd;
      wr_i <= !is_rd;
      @(negedge clk);
      check_bit(xram_ce_o, exp_xram_ce(a, is_rd), $sformatf("xram_ce at %h rd %b", a, is_rd));
      check_bit(vdp_ce_o, (a[15:8] == 8'h88 && is_rd) || (a[15:8] == 8'h8C && !is_rd),
                $sformatf("vdp_ce at %h rd %b", a, is_rd));
      check_region(region_o, exp_region(a), $sformatf("region at %h", a));
      check_bit(cart_cs_o, a[15:13] == 3'b011, $sformatf("cart_cs at %h", a));
      check_bit(grom_rd_o, is_rd && a[15:8] == 8'h98,
                $sformatf("grom_rd at %h rd %b", a, is_rd));
      check_bit(mem_active_n_o, !exp_xram_ce(a, is_rd),
                $sformatf("mem_active_n at %h rd %b", a, is_rd));
    end
    @(posedge clk);
    rd_i <= 1'b0;
    wr_i <= 1'b0;
    finish_test("memory map", e0);
  endtask

  // Held write of kind 0 VDP, 1 GROM or 2 sound
  task automatic write_burst(input byte_t page, input int kind);
    logic [2:0]  exp;
    logic [31:0] r;
    r = lcg_next();
    @(posedge clk);
    ab_i <= {page, r[23:16]};
    wr_i <= 1'b1;
    for (int c = 0; c < 5; c++) begin
      @(negedge clk);
      exp = (c == 0) ? (3'b100 >> kind) : 3'b000;  // Pulse in first cycle only
      check_byte({5'b0, vdp_wr_o, grom_wr_o, sound_wr_o}, {5'b0, exp},
                 $sformatf("strobes page %h cycle %0d", page, c));
      check_bit(mem_wr_rq_o, c == 0, $sformatf("mem_wr_rq page %h cycle %0d", page, c));
    end
    @(posedge clk);
    wr_i <= 1'b0;
    @(posedge clk);  // Idle cycle between writes
  endtask

  task automatic test_strobes();
    int e0;
    e0 = errors;
    write_burst(8'h8C, 0);
    write_burst(8'h9C, 1);
    write_burst(8'h84, 2);
    @(posedge clk);
    ab_i <= 16'h8800;
    rd_i <= 1'b1;
    for (int c = 0; c < 4; c++) begin
      @(negedge clk);
      check_bit(vdp_rd_o, 1'b1, "vdp_rd level during read");
      check_bit(mem_rd_rq_o, c == 0, "mem_rd_rq pulse");
    end
    @(posedge clk);
    rd_i <= 1'b0;
    finish_test("strobes", e0);
  endtask

  task automatic test_banking();
    logic [31:0] r;
    cart_page_t  bank;
    cpu_word_t   a;
    int          e0;
    e0 = errors;
    r = lcg_next();
    bank = r[23:16];
    @(posedge clk);
    ab_i <= 16'h6000 | {7'b0, bank, 1'b0};  // Bank number on address bits 8..1
    wr_i <= 1'b1;
    @(posedge clk);
    wr_i <= 1'b0;
    @(negedge clk);
    check_byte(cart_page_o, bank, "bank after cartridge write");
    a = {3'b011, r[12:0]};
    @(posedge clk);
    ab_i <= a;
    rd_i <= 1'b1;
    @(negedge clk);
    check_xaddr(xaddr_o, {3'b001, bank, a[12:1]}, "cartridge read address");
    @(posedge clk);
    ab_i <= 16'h9800;
    grom_selected_i <= 1'b1;
    grom_addr_i <= r[31:12];
    @(negedge clk);
    check_xaddr(xaddr_o, {8'h01, r[27:13]}, "GROM read address");  // GROM bits 15..1
    a = {3'b101, r[12:0]};
    @(posedge clk);
    grom_selected_i <= 1'b0;
    ab_i <= a;
    @(negedge clk);
    check_xaddr(xaddr_o, {8'h00, a[15:1]}, "RAM read address");
    @(posedge clk);
    rd_i <= 1'b0;
    cpu_reset <= 1'b1;
    @(posedge clk);
    cpu_reset <= 1'b0;
    ab_i <= 16'h6002;
    rd_i <= 1'b1;
    @(negedge clk);
    check_byte(cart_page_o, 8'h00, "bank after reset");
    check_xaddr(xaddr_o, 23'h10_0001, "cartridge address after reset");
    @(posedge clk);
    rd_i <= 1'b0;
    finish_test("banking", e0);
  endtask

  task automatic test_ready();
    int e0;
    e0 = errors;
    @(posedge clk);
    ab_i <= 16'h2000;
    rd_i <= 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_bit(cpu_ready_o, 1'b0, "ready before ack");
    end
    @(posedge clk);
    mem_rd_ack_i <= 1'b1;
    @(negedge clk);
    check_bit(cpu_ready_o, 1'b1, "ready in ack cycle");
    @(posedge clk);
    mem_rd_ack_i <= 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_bit(cpu_ready_o, 1'b1, "ready held until cycle end");
    end
    @(posedge clk);
    rd_i <= 1'b0;
    @(negedge clk);  // Held flag clears at the next edge
    @(negedge clk);
    check_bit(cpu_ready_o, 1'b0, "ready after cycle end");
    @(posedge clk);
    rd_i <= 1'b1;
    repeat (6) begin
      @(negedge clk);
      check_bit(cpu_ready_o, 1'b0, "ready without ack");
    end
    @(posedge clk);
    vdp_rd_ack_i <= 1'b1;
    vdp_wr_ack_i <= 1'b1;
    @(negedge clk);
    check_bit(cpu_ready_o, 1'b0, "VDP ack on memory cycle");
    @(posedge clk);
    vdp_rd_ack_i <= 1'b0;
    vdp_wr_ack_i <= 1'b0;
    rd_i <= 1'b0;
    finish_test("ready", e0);
  endtask

  task automatic mux_case(input cpu_word_t a, input logic gsel, input logic greg,
                          input grom_addr_t g, input cpu_word_t exp, input string msg);
    @(posedge clk);
    ab_i <= a;
    rd_i <= 1'b1;
    grom_selected_i <= gsel;
    grom_reg_out_i <= greg;
    grom_addr_i <= g;
    @(negedge clk);
    check_word(db_in_o, exp, msg);
  endtask

  task automatic test_read_mux();
    logic [31:0] r;
    cpu_word_t   vd, xd;
    byte_t       gd;
    int          e0;
    e0 = errors;
    r = lcg_next();
    vd = r[31:16];
    xd = r[15:0];
    r = lcg_next();
    gd = r[31:24];
    @(posedge clk);
    vdp_data_i <= vd;
    xram_data_i <= xd;
    grom_data_i <= gd;
    mux_case(16'h8800, 1'b0, 1'b1, '0, vd, "VDP read over GROM register");
    mux_case(16'h9802, 1'b0, 1'b1, '0, {gd, 8'h00}, "GROM register read");
    mux_case(16'h9800, 1'b1, 1'b0, 20'h00001, {xd[7:0], 8'h00}, "GROM odd byte");
    mux_case(16'h9800, 1'b1, 1'b0, 20'h00002, {xd[15:8], 8'h00}, "GROM even byte");
    mux_case(16'h9802, 1'b0, 1'b0, '0, 16'hFF00, "GROM open bus");
    mux_case(16'h2000, 1'b0, 1'b0, '0, xd, "RAM read");
    mux_case(16'h4000, 1'b0, 1'b0, '0, 16'h0000, "unmapped read");
    @(posedge clk);
    rd_i <= 1'b0;
    grom_selected_i <= 1'b0;
    finish_test("read mux", e0);
  endtask

  // One loader request in the window held until its ack
  task automatic loader_access(input logic is_wr, input logic [11:0] off,
                               input byte_t wdata, output byte_t rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    loader_addr_i <= 32'h0100_0000 | off;  // Bit 24 opens the window
    loader_wdata_i <= wdata;
    if (is_wr)
      loader_wr_rq_i <= 1'b1;
    else
      loader_rd_rq_i <= 1'b1;
    @(negedge clk);
    while (!(loader_rd_ack_o || loader_wr_ack_o) && waited < 8) begin
      @(negedge clk);
      waited++;
    end
    if (!(loader_rd_ack_o || loader_wr_ack_o)) begin
      errors++;
      $display("Loader request at offset %h was never acknowledged", off);
    end else begin
      check_bit(waited == 1, 1'b1, "loader ack one cycle after request");
      check_bit(loader_wr_ack_o, is_wr, "loader ack type");
    end
    rdata = loader_rdata_o;
    @(posedge clk);
    loader_wr_rq_i <= 1'b0;
    loader_rd_rq_i <= 1'b0;
  endtask

  task automatic test_loader();
    byte_t       rows [KEY_ROWS];
    byte_t       rb;
    logic [31:0] r;
    cpu_word_t   hist [3];
    int          e0;
    e0 = errors;
    for (int i = 0; i < KEY_ROWS; i++) begin
      r = lcg_next();
      rows[i] = r[23:16];
      loader_access(1'b1, 12'(i), rows[i], rb);
    end
    for (int i = 0; i < KEY_ROWS; i++) begin
      loader_access(1'b0, 12'(i), 8'h00, rb);
      check_byte(rb, rows[i], $sformatf("key row %0d readback", i));
    end
    for (int i = 0; i < KEY_ROWS; i++) begin
      r = lcg_next();
      @(posedge clk);
      key_row_sel_i <= i[KEY_ROW_W-1:0];
      ps2_keyline_i <= r[23:16];
      @(negedge clk);
      check_byte(key_cols_o, rows[i] & r[23:16], $sformatf("key columns row %0d", i));
    end
    loader_access(1'b1, 12'h008, 8'hFE, rb);
    @(negedge clk);
    check_bit(cpu_reset_req_o, 1'b1, "reset request with bit 0 clear");
    loader_access(1'b0, 12'h009, 8'h00, rb);
    check_byte(rb, 8'hFE, "reset control readback");
    loader_access(1'b1, 12'h008, 8'hFF, rb);
    @(negedge clk);
    check_bit(cpu_reset_req_o, 1'b0, "reset request released");
    r = lcg_next();
    hist[0] = r[31:16];
    hist[1] = r[15:0];
    r = lcg_next();
    hist[2] = r[31:16];
    @(posedge clk);
    cpu_ir_i <= hist[0];
    cpu_ir_pc_i <= hist[1];
    cpu_ir_pc2_i <= hist[2];
    for (int k = 0; k < 6; k++) begin
      loader_access(1'b0, 12'h00A + 12'(k), 8'h00, rb);
      check_byte(rb, k[0] ? hist[k/2][7:0] : hist[k/2][15:8], $sformatf("history byte %0d", k));
    end
    loader_access(1'b0, 12'h100, 8'h00, rb);
    check_byte(rb, 8'h00, "unmapped loader read");
    // Request with bit 24 clear is not for this window
    @(posedge clk);
    loader_addr_i <= 32'h0000_0000;
    loader_wdata_i <= 8'h00;
    loader_wr_rq_i <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_bit(loader_wr_ack_o, 1'b0, "ack outside window");
      check_bit(cpu_hold_o, 1'b1, "CPU hold during request");
    end
    @(posedge clk);
    loader_wr_rq_i <= 1'b0;
    loader_access(1'b0, 12'h000, 8'h00, rb);
    check_byte(rb, rows[0], "key row 0 kept");
    finish_test("loader", e0);
  endtask

  // ------------------------------------------------------------------
  // Main sequence and watchdog
  // ------------------------------------------------------------------
  initial begin
    clk = 1'b0;
    cpu_reset = 1'b1;
    ab_i = '0;
    rd_i = 1'b0;
    wr_i = 1'b0;
    grom_selected_i = 1'b0;
    grom_reg_out_i = 1'b0;
    grom_addr_i = '0;
    grom_data_i = '0;
    vdp_data_i = '0;
    xram_data_i = '0;
    mem_rd_ack_i = 1'b0;
    mem_wr_ack_i = 1'b0;
    vdp_rd_ack_i = 1'b0;
    vdp_wr_ack_i = 1'b0;
    loader_addr_i = '0;
    loader_rd_rq_i = 1'b0;
    loader_wr_rq_i = 1'b0;
    loader_wdata_i = '0;
    cpu_ir_i = '0;
    cpu_ir_pc_i = '0;
    cpu_ir_pc2_i = '0;
    reset_switch_n_i = 1'b1;  // Switch released
    key_row_sel_i = '0;
    ps2_keyline_i = 8'hFF;    // No PS/2 key down
    repeat (16) @(posedge clk);
    cpu_reset <= 1'b0;
    test_memory_map();
    test_strobes();
    test_banking();
    test_ready();
    test_read_mux();
    test_loader();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Run timed out before all tests finished");
    $display("Done: errors found");
    $finish;
  end

endmodule

/* ti_glue_top.sv */
// Bus glue of the console, CPU side
// Connects the decoder, address mapper, ready logic and loader window
module ti_glue_top import ti_bus_pkg::*, ti_loader_pkg::*; (
  input  logic                 clk,
  input  logic                 cpu_reset,
  // CPU bus
  input  cpu_word_t            ab_i,
  input  logic                 rd_i,
  input  logic                 wr_i,
  output cpu_word_t            db_in_o,
  output logic                 cpu_ready_o,
  // GROM controller, VDP and memory
  input  logic                 grom_selected_i,
  input  logic                 grom_reg_out_i,
  input  grom_addr_t           grom_addr_i,
  input  byte_t                grom_data_i,
  input  cpu_word_t            vdp_data_i,
  input  cpu_word_t            xram_data_i,
  input  logic                 mem_rd_ack_i,
  input  logic                 mem_wr_ack_i,
  input  logic                 vdp_rd_ack_i,
  input  logic                 vdp_wr_ack_i,
  output mem_region_e          region_o,
  output logic                 cart_cs_o,
  output logic                 xram_ce_o,
  output logic                 vdp_ce_o,
  output logic                 vdp_rd_o,
  output logic                 vdp_wr_o,
  output logic                 grom_rd_o,
  output logic                 grom_wr_o,
  output logic                 sound_wr_o,
  output logic                 mem_rd_rq_o,
  output logic                 mem_wr_rq_o,
  output logic                 mem_active_n_o,
  output cart_page_t           cart_page_o,
  output xaddr_t               xaddr_o,
  // Loader port
  input  loader_addr_t         loader_addr_i,
  input  logic                 loader_rd_rq_i,
  input  logic                 loader_wr_rq_i,
  input  byte_t                loader_wdata_i,
  output byte_t                loader_rdata_o,
  output logic                 loader_rd_ack_o,
  output logic                 loader_wr_ack_o,
  // CPU history, reset and keyboard
  input  cpu_word_t            cpu_ir_i,
  input  cpu_word_t            cpu_ir_pc_i,
  input  cpu_word_t            cpu_ir_pc2_i,
  input  logic                 reset_switch_n_i,
  input  logic [KEY_ROW_W-1:0] key_row_sel_i,
  input  byte_t                ps2_keyline_i,
  output logic                 cpu_hold_o,
  output logic                 cpu_reset_req_o,
  output byte_t                key_cols_o
);

  bus_decoder u_dec (.*);

  // Bank load and address choice use the decoder outputs
  xaddr_mapper u_xmap (.*, .cart_cs_i(cart_cs_o), .mem_wr_rq_i(mem_wr_rq_o));

  ready_ctrl u_rdy (.*, .xram_ce_i(xram_ce_o), .vdp_ce_i(vdp_ce_o));

  loader_regs u_ldr (.*);

endmodule

/* loader_regs.sv */
// Loader register window at loader address bit 24
// Keyboard matrix rows, CPU reset control and CPU history readback
// Also merges the scanned key row with the PS/2 key line
module loader_regs import ti_bus_pkg::*, ti_loader_pkg::*; (
  input  logic                 clk,
  input  logic                 cpu_reset,
  input  loader_addr_t         loader_addr_i,
  input  logic                 loader_rd_rq_i,   // Held until ack
  input  logic                 loader_wr_rq_i,
  input  byte_t                loader_wdata_i,
  input  cpu_word_t            cpu_ir_i,         // Instruction register
  input  cpu_word_t            cpu_ir_pc_i,      // PC at that instruction
  input  cpu_word_t            cpu_ir_pc2_i,     // Previous PC
  input  logic                 reset_switch_n_i,
  input  logic [KEY_ROW_W-1:0] key_row_sel_i,    // Row scanned by the 9901
  input  byte_t                ps2_keyline_i,
  output byte_t                loader_rdata_o,
  output logic                 loader_rd_ack_o,
  output logic                 loader_wr_ack_o,
  output logic                 cpu_hold_o,
  output logic                 cpu_reset_req_o,
  output byte_t                key_cols_o
);

  byte_t       key_rows [KEY_ROWS];  // Active low with one bit per key
  byte_t       reset_ctrl;           // Bit 0 low holds the CPU in reset
  logic        window;
  logic        idle;
  logic        wr_take, rd_take;
  loader_reg_e rd_sel;
  byte_t       rd_byte;

  assign window  = loader_addr_i[LOADER_WINDOW_BIT];
  assign idle    = !loader_rd_ack_o && !loader_wr_ack_o;  // One ack per request
  assign wr_take = loader_wr_rq_i && window && idle;
  assign rd_take = loader_rd_rq_i && window && idle && !loader_wr_rq_i;

  // ------------------------------------------------------------------
  // Read select and readback byte
  // ------------------------------------------------------------------
  always_comb begin
    if (loader_addr_i[11:4] != 8'h00) begin
      rd_sel = LR_NONE;
    end else if (!loader_addr_i[3]) begin
      rd_sel = LR_KEY_ROW;     // 000..007
    end else begin
      case (loader_addr_i[2:0])
        3'd0, 3'd1: rd_sel = LR_RESET_CTRL;
        3'd2:       rd_sel = LR_IR_HI;
        3'd3:       rd_sel = LR_IR_LO;
        3'd4:       rd_sel = LR_PC_HI;
        3'd5:       rd_sel = LR_PC_LO;
        3'd6:       rd_sel = LR_PC2_HI;
        default:    rd_sel = LR_PC2_LO;
      endcase
    end
  end

  always_comb begin
    case (rd_sel)
      LR_KEY_ROW:    rd_byte = key_rows[loader_addr_i[KEY_ROW_W-1:0]];
      LR_RESET_CTRL: rd_byte = reset_ctrl;
      LR_IR_HI:      rd_byte = cpu_ir_i[15:8];
      LR_IR_LO:      rd_byte = cpu_ir_i[7:0];
      LR_PC_HI:      rd_byte = cpu_ir_pc_i[15:8];
      LR_PC_LO:      rd_byte = cpu_ir_pc_i[7:0];
      LR_PC2_HI:     rd_byte = cpu_ir_pc2_i[15:8];
      LR_PC2_LO:     rd_byte = cpu_ir_pc2_i[7:0];
      default:       rd_byte = '0;
    endcase
  end

  // Registers and acknowledges
  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      for (int i = 0; i < KEY_ROWS; i++) begin
        key_rows[i] <= KEY_UP_ROW;
      end
      reset_ctrl      <= RESET_CTRL_INIT;
      loader_rd_ack_o <= 1'b0;
      loader_wr_ack_o <= 1'b0;
    end else begin
      loader_wr_ack_o <= wr_take;  // Pulse after the sampled request
      loader_rd_ack_o <= rd_take;
      if (wr_take) begin
        case (loader_addr_i[4:3])
          2'b00:   key_rows[loader_addr_i[KEY_ROW_W-1:0]] <= loader_wdata_i;
          2'b01:   reset_ctrl <= loader_wdata_i;
          default: ;  // Acked but nothing stored
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_take) begin
      loader_rdata_o <= rd_byte;  // Valid with the read ack
    end
  end

  // ------------------------------------------------------------------
  // Outputs to the CPU and the 9901
  // ------------------------------------------------------------------
  assign cpu_hold_o      = loader_rd_rq_i || loader_wr_rq_i;
  assign cpu_reset_req_o = !reset_switch_n_i || !reset_ctrl[0];
  assign key_cols_o      = key_rows[key_row_sel_i] & ps2_keyline_i;  // Low = pressed

  a_ack_excl: assert property (@(posedge clk) disable iff (cpu_reset)
    !(loader_rd_ack_o && loader_wr_ack_o));

endmodule

/* ready_ctrl.sv */
// CPU ready generation
// Ready follows the acknowledge of the selected target and is held
// until the CPU ends the bus cycle, so short acks are not lost
module ready_ctrl (
  input  logic clk,
  input  logic cpu_reset,
  input  logic rd_i,
  input  logic wr_i,
  input  logic xram_ce_i,
  input  logic vdp_ce_i,
  input  logic mem_rd_ack_i,
  input  logic mem_wr_ack_i,
  input  logic vdp_rd_ack_i,
  input  logic vdp_wr_ack_i,
  output logic cpu_ready_o
);

  logic ready_now;  // Ack from the selected target this cycle
  logic held;       // Ack seen earlier in this bus cycle

  assign ready_now = (xram_ce_i && (mem_rd_ack_i || mem_wr_ack_i)) ||
                     (vdp_ce_i && (vdp_rd_ack_i || vdp_wr_ack_i));

  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      held <= 1'b0;
    end else if (!rd_i && !wr_i) begin
      held <= 1'b0;              // Bus cycle over
    end else if (ready_now) begin
      held <= 1'b1;
    end
  end

  assign cpu_ready_o = ready_now || held;  // Same cycle as the ack

  // Ready only inside a bus cycle or in the cycle right after it
  a_ready_in_cycle: assert property (@(posedge clk) disable iff (cpu_reset)
    cpu_ready_o && !(rd_i || wr_i) |-> $past(rd_i || wr_i));

endmodule

/* xaddr_mapper.sv */
// Maps CPU and GROM addresses onto the external memory word address
// Holds the cartridge bank, written through the address bus
// on any write to cartridge space (Extended Basic style)
module xaddr_mapper import ti_bus_pkg::*; (
  input  logic       clk,
  input  logic       cpu_reset,
  input  cpu_word_t  ab_i,
  input  logic       cart_cs_i,
  input  logic       mem_wr_rq_i,      // First cycle of a CPU write
  input  logic       grom_selected_i,
  input  grom_addr_t grom_addr_i,
  output cart_page_t cart_page_o,
  output xaddr_t     xaddr_o
);

  xaddr_t grom_xaddr, cart_xaddr, cpu_xaddr;

  // Bank register loads from address bits and not from data
  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      cart_page_o <= '0;
    end else if (mem_wr_rq_i && cart_cs_i) begin
      cart_page_o <= ab_i[8:1];
    end
  end

  // ------------------------------------------------------------------
  // Address candidates on bases with clear low bits
  // ------------------------------------------------------------------
  assign grom_xaddr = GROM_XBASE | {8'h00, grom_addr_i[15:1]};
  assign cart_xaddr = CART_XBASE | {3'b000, cart_page_o, ab_i[12:1]};
  assign cpu_xaddr  = CPU_XBASE | {8'h00, ab_i[15:1]};

  always_comb begin
    if (grom_selected_i)
      xaddr_o = grom_xaddr;  // GROM wins over CPU space
    else if (cart_cs_i)
      xaddr_o = cart_xaddr;
    else
      xaddr_o = cpu_xaddr;
  end

  // GROM fetches land in the GROM image
  a_grom_base: assert property (@(posedge clk) disable iff (cpu_reset)
    grom_selected_i |-> xaddr_o[22:15] == GROM_XBASE[22:15]);

endmodule

/* bus_decoder.sv */
// CPU memory map decode for the console
// Gives chip selects, device strobes, memory requests and the read word
// Strobes on writes fire once, in the first cycle of the CPU bus cycle
module bus_decoder import ti_bus_pkg::*; (
  input  logic        clk,
  input  logic        cpu_reset,
  input  cpu_word_t   ab_i,             // CPU address
  input  logic        rd_i,
  input  logic        wr_i,
  input  logic        grom_selected_i,  // GROM data comes from memory
  input  logic        grom_reg_out_i,   // GROM controller register read
  input  grom_addr_t  grom_addr_i,
  input  byte_t       grom_data_i,
  input  cpu_word_t   vdp_data_i,
  input  cpu_word_t   xram_data_i,
  output mem_region_e region_o,
  output logic        cart_cs_o,
  output logic        xram_ce_o,
  output logic        vdp_ce_o,
  output logic        vdp_rd_o,
  output logic        vdp_wr_o,
  output logic        grom_rd_o,
  output logic        grom_wr_o,
  output logic        sound_wr_o,
  output logic        mem_rd_rq_o,
  output logic        mem_wr_rq_o,
  output logic        mem_active_n_o,
  output cpu_word_t   db_in_o           // Read word to the CPU
);

  byte_t page;          // High address byte
  logic  rd_q, wr_q;    // Bus levels of the previous cycle
  logic  rd_rise, wr_rise;

  assign page = ab_i[15:8];

  // ------------------------------------------------------------------
  // Region decode
  // ------------------------------------------------------------------
  always_comb begin
    casez (page)
      8'b000?_????: region_o = REG_ROM;
      8'b001?_????: region_o = REG_LOW_RAM;
      8'b011?_????: region_o = REG_CART;
      8'b1000_00??: region_o = REG_SCRATCH;
      SOUND_PAGE:   region_o = REG_SOUND;
      VDP_RD_PAGE:  region_o = REG_VDP_RD;
      VDP_WR_PAGE:  region_o = REG_VDP_WR;
      GROM_RD_PAGE: region_o = REG_GROM_RD;
      GROM_WR_PAGE: region_o = REG_GROM_WR;
      8'b101?_????, 8'b11??_????: region_o = REG_HIGH_RAM;  // A000..FFFF
      default:      region_o = REG_OTHER;
    endcase
  end

  // External memory select, ROM and cartridge are write protected
  always_comb begin
    case (region_o)
      REG_ROM, REG_CART:                      xram_ce_o = !wr_i;
      REG_LOW_RAM, REG_SCRATCH, REG_HIGH_RAM: xram_ce_o = 1'b1;
      REG_GROM_RD:                            xram_ce_o = !ab_i[1];  // GROM data port only
      default:                                xram_ce_o = 1'b0;
    endcase
  end

  assign cart_cs_o = (region_o == REG_CART);
  assign vdp_ce_o  = (region_o == REG_VDP_RD && rd_i) || (region_o == REG_VDP_WR && wr_i);

  // ------------------------------------------------------------------
  // Strobes
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      rd_q <= 1'b0;
      wr_q <= 1'b0;
    end else begin
      rd_q <= rd_i;
      wr_q <= wr_i;
    end
  end

  assign rd_rise = rd_i && !rd_q;  // First cycle of a read
  assign wr_rise = wr_i && !wr_q;

  assign vdp_rd_o   = rd_i && (region_o == REG_VDP_RD);   // Level
  assign grom_rd_o  = rd_i && (region_o == REG_GROM_RD);  // Level
  assign vdp_wr_o   = wr_rise && (region_o == REG_VDP_WR);
  assign grom_wr_o  = wr_rise && (region_o == REG_GROM_WR);
  assign sound_wr_o = wr_rise && (region_o == REG_SOUND);

  assign mem_rd_rq_o    = rd_rise;
  assign mem_wr_rq_o    = wr_rise;
  assign mem_active_n_o = !((rd_i || wr_i) && (xram_ce_o || grom_selected_i));

  // Read word, in priority order
  always_comb begin
    if (vdp_rd_o)
      db_in_o = vdp_data_i;
    else if (grom_reg_out_i)
      db_in_o = {grom_data_i, 8'h00};      // GROM address readback
    else if (grom_selected_i && grom_addr_i[0])
      db_in_o = {xram_data_i[7:0], 8'h00}; // Odd GROM byte
    else if (grom_selected_i)
      db_in_o = {xram_data_i[15:8], 8'h00};
    else if (region_o == REG_GROM_RD)
      db_in_o = OPEN_BUS_WORD;             // No GROM at this address
    else if (xram_ce_o)
      db_in_o = xram_data_i;
    else
      db_in_o = '0;
  end

  // VDP reads never reach external memory
  a_vdp_xram_excl: assert property (@(posedge clk) disable iff (cpu_reset)
    !(vdp_rd_o && xram_ce_o));

endmodule

/* ti_loader_pkg.sv */
// Loader register window definitions
// Window address bit, keyboard matrix size and readback select
// Imported by the loader register block and top level
package ti_loader_pkg;

  typedef logic [31:0] loader_addr_t;  // Loader byte address

  localparam int LOADER_WINDOW_BIT = 24;  // Set for register accesses

  // Keyboard matrix
  localparam int KEY_ROWS  = 8;
  localparam int KEY_ROW_W = 3;   // Row index width

  localparam logic [7:0] KEY_UP_ROW      = 8'hFF;  // All keys released
  localparam logic [7:0] RESET_CTRL_INIT = 8'hFF;  // Bit 0 high, CPU runs

  // Readback register of a loader read
  typedef enum logic [3:0] {
    LR_KEY_ROW,     // 000..007
    LR_RESET_CTRL,  // 008..009
    LR_IR_HI,       // 00A
    LR_IR_LO,
    LR_PC_HI,       // 00C
    LR_PC_LO,
    LR_PC2_HI,      // 00E
    LR_PC2_LO,
    LR_NONE         // Reads as zero
  } loader_reg_e;

endpackage

/* ti_bus_pkg.sv */
// CPU bus side definitions of the console glue
// Word types, memory map pages and external memory layout
// Imported by the decoder, address mapper and top level
package ti_bus_pkg;

  typedef logic [15:0] cpu_word_t;   // CPU address or data word
  typedef logic [22:0] xaddr_t;      // External memory word address
  typedef logic [19:0] grom_addr_t;  // GROM address counter
  typedef logic [7:0]  byte_t;
  typedef logic [7:0]  cart_page_t;  // Cartridge bank number

  // Region of a CPU address
  typedef enum logic [3:0] {
    REG_ROM,       // 0000..1FFF console ROM
    REG_LOW_RAM,   // 2000..3FFF
    REG_CART,      // 6000..7FFF cartridge
    REG_SCRATCH,   // 8000..83FF scratchpad
    REG_SOUND,     // 84xx
    REG_VDP_RD,    // 88xx
    REG_VDP_WR,    // 8Cxx
    REG_GROM_RD,   // 98xx
    REG_GROM_WR,   // 9Cxx
    REG_HIGH_RAM,  // A000..FFFF
    REG_OTHER
  } mem_region_e;

  // ------------------------------------------------------------------
  // Memory mapped device pages, high address byte
  // ------------------------------------------------------------------
  localparam byte_t SOUND_PAGE   = 8'h84;
  localparam byte_t VDP_RD_PAGE  = 8'h88;
  localparam byte_t VDP_WR_PAGE  = 8'h8C;
  localparam byte_t GROM_RD_PAGE = 8'h98;
  localparam byte_t GROM_WR_PAGE = 8'h9C;

  // ------------------------------------------------------------------
  // External memory layout, word addresses
  // ------------------------------------------------------------------
  localparam xaddr_t GROM_XBASE = 23'h00_8000;  // Upper byte 01h
  localparam xaddr_t CART_XBASE = 23'h10_0000;  // Upper bits 001b, 256 banks of 8K
  localparam xaddr_t CPU_XBASE  = 23'h00_0000;  // CPU space at the bottom

  // GROM port read with no GROM behind it
  localparam cpu_word_t OPEN_BUS_WORD = 16'hFF00;

endpackage
